// File: verilog/soc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// soc package
// memory map, bus widths and reset values for the peripheral side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_pkg;

    localparam int addr_width     = 24;
    localparam int data_width     = 32;
    localparam int strb_width     = data_width / 8;
    localparam int ram_words      = 2048;
    localparam int ram_addr_width = 11;

    // region codes live in address bits 23..20
    localparam logic [3:0] region_ram    = 4'd0;
    localparam logic [3:0] region_status = 4'd1;
    localparam logic [3:0] region_dsp    = 4'd2;

    // red LED on out of reset
    localparam logic [1:0] status_reset = 2'b01;

    // cpu address seen either as one word or split into fields
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [3:0]                region;
            logic [6:0]                unused;
            logic [ram_addr_width-1:0] word_index;
            logic [1:0]                byte_offset;
        } fields;
    } cpu_addr_t;

endpackage

// File: verilog/cpu_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu bus interface
// request side of the picorv32 style memory bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface cpu_bus_if;

    soc_pkg::cpu_addr_t                  address;
    logic [soc_pkg::data_width-1:0]      write_data;
    logic [soc_pkg::strb_width-1:0]      wstrb;
    logic                                mem_valid;

    // region decode and access tracking
    modport decoder (input address, input wstrb, input mem_valid);

    // ram steering
    modport arbiter (input address, input write_data, input wstrb);

    // register writes
    modport regs (input address, input write_data);

    // driven from the top level ports
    modport source (output address, output write_data, output wstrb, output mem_valid);

endinterface

// File: verilog/address_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address decoder
// turns a new cpu request into a one cycle region enable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module address_decoder (
    input  logic       vdp_clk,
    input  logic       vdp_reset,
    cpu_bus_if.decoder bus,
    output logic       ram_en,
    output logic       status_en,
    output logic       dsp_en,
    output logic       none_en,
    output logic       write_en
);

    logic busy;
    logic fire;

    // only the first cycle of a held request counts
    assign fire = bus.mem_valid && !busy;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ram_en    <= 1'b0;
            status_en <= 1'b0;
            dsp_en    <= 1'b0;
            none_en   <= 1'b0;
            write_en  <= 1'b0;
            busy      <= 1'b0;
        end else begin
            ram_en    <= 1'b0;
            status_en <= 1'b0;
            dsp_en    <= 1'b0;
            none_en   <= 1'b0;
            write_en  <= fire && (|bus.wstrb);

            if (fire) begin
                case (bus.address.fields.region)
                    soc_pkg::region_ram:    ram_en    <= 1'b1;
                    soc_pkg::region_status: status_en <= 1'b1;
                    soc_pkg::region_dsp:    dsp_en    <= 1'b1;
                    default:                none_en   <= 1'b1;
                endcase
            end

            // busy until the cpu lets go of valid
            if (fire) begin
                busy <= 1'b1;
            end else if (!bus.mem_valid) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/bus_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus arbiter
// routes each access to its target, returns read data and ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bus_arbiter (
    input  logic                              vdp_clk,
    input  logic                              vdp_reset,
    cpu_bus_if.arbiter                        bus,

    input  logic                              ram_en,
    input  logic                              status_en,
    input  logic                              dsp_en,
    input  logic                              none_en,
    input  logic                              write_en,

    input  logic [soc_pkg::data_width-1:0]    status_read_data,
    input  logic [soc_pkg::data_width-1:0]    dsp_result,
    input  logic [soc_pkg::data_width-1:0]    ram_read_data,

    output logic                              ram_cs,
    output logic [soc_pkg::strb_width-1:0]    ram_wstrb,
    output logic [soc_pkg::ram_addr_width-1:0] ram_address,
    output logic [soc_pkg::data_width-1:0]    ram_write_data,

    output logic                              cpu_mem_ready,
    output logic [soc_pkg::data_width-1:0]    cpu_read_data
);

    logic sel_ram;
    logic sel_status;
    logic sel_dsp;

    // ram port comes straight from the held request
    assign ram_cs         = ram_en;
    assign ram_address    = bus.address.fields.word_index;
    assign ram_write_data = bus.write_data;

    // strobes only reach the ram on a write to it
    assign ram_wstrb = (ram_en && write_en) ? bus.wstrb : '0;

    // ready follows the enable by one cycle
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_mem_ready <= 1'b0;
            sel_ram       <= 1'b0;
            sel_status    <= 1'b0;
            sel_dsp       <= 1'b0;
        end else begin
            cpu_mem_ready <= ram_en || status_en || dsp_en || none_en;
            sel_ram       <= ram_en;
            sel_status    <= status_en;
            sel_dsp       <= dsp_en;
        end
    end

    // unmapped regions read as zero
    always_comb begin
        if (sel_ram) begin
            cpu_read_data = ram_read_data;
        end else if (sel_status) begin
            cpu_read_data = status_read_data;
        end else if (sel_dsp) begin
            cpu_read_data = dsp_result;
        end else begin
            cpu_read_data = '0;
        end
    end

endmodule

// File: verilog/cpu_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu ram
// single port word ram with byte strobes and registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu_ram (
    input  logic                               vdp_clk,
    input  logic                               cs,
    input  logic [soc_pkg::strb_width-1:0]     wstrb,
    input  logic [soc_pkg::ram_addr_width-1:0] address,
    input  logic [soc_pkg::data_width-1:0]     write_data,
    output logic [soc_pkg::data_width-1:0]     read_data
);

    logic [soc_pkg::data_width-1:0] mem [soc_pkg::ram_words];

    // byte lanes written independently
    always_ff @(posedge vdp_clk) begin
        if (cs) begin
            for (int i = 0; i < soc_pkg::strb_width; i++) begin
                if (wstrb[i]) begin
                    mem[address][8*i +: 8] <= write_data[8*i +: 8];
                end
            end
        end
    end

    // read returns the word before any write in the same cycle
    always_ff @(posedge vdp_clk) begin
        if (cs) begin
            read_data <= mem[address];
        end
    end

endmodule

// File: verilog/system_registers.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system registers
// status LEDs and a signed 16x16 multiplier for the cpu
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module system_registers (
    input  logic                           vdp_clk,
    input  logic                           vdp_reset,
    cpu_bus_if.regs                        bus,
    input  logic                           status_en,
    input  logic                           dsp_en,
    input  logic                           write_en,
    output logic                           led_r,
    output logic                           led_b,
    output logic [soc_pkg::data_width-1:0] status_read_data,
    output logic [soc_pkg::data_width-1:0] dsp_result
);

    logic [1:0]  status;
    logic [15:0] dsp_mult_a;
    logic [15:0] dsp_mult_b;
    logic        dsp_write;
    logic        operand_sel;

    assign dsp_write   = dsp_en && write_en;
    // word 0 is operand a, word 1 is operand b
    assign operand_sel = bus.address.fields.word_index[0];

    // status register
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= soc_pkg::status_reset;
        end else if (status_en && write_en) begin
            status <= bus.write_data[1:0];
        end
    end

    assign led_r = status[0];
    assign led_b = status[1];

    assign status_read_data = {{(soc_pkg::data_width-2){1'b0}}, status};

    // one register per multiplier operand
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            dsp_mult_a <= '0;
        end else if (dsp_write && !operand_sel) begin
            dsp_mult_a <= bus.write_data[15:0];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            dsp_mult_b <= '0;
        end else if (dsp_write && operand_sel) begin
            dsp_mult_b <= bus.write_data[15:0];
        end
    end

    // signed product updated every cycle
    always_ff @(posedge vdp_clk) begin
        dsp_result <= $signed(dsp_mult_a) * $signed(dsp_mult_b);
    end

endmodule

// File: verilog/cpu_irq_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu interrupt control
// holds frame and raster requests until the cpu signals eoi
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu_irq_control (
    input  logic       vdp_clk,
    input  logic       vdp_reset,
    input  logic       frame_irq_requested,
    input  logic       raster_irq_requested,
    input  logic       irq_acknowledge,
    input  logic       raster_irq_acknowledge,
    output logic [1:0] irq
);

    logic [1:0] requested;
    logic [1:0] requested_r;
    logic [1:0] acknowledge;
    logic [1:0] request_edge;

    // bit 0 frame, bit 1 raster
    assign requested   = {raster_irq_requested, frame_irq_requested};
    assign acknowledge = {raster_irq_acknowledge, irq_acknowledge};

    assign request_edge = requested & ~requested_r;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            requested_r <= 2'b00;
            irq         <= 2'b00;
        end else begin
            requested_r <= requested;
            // a new edge beats an eoi in the same cycle
            irq         <= (irq & ~acknowledge) | request_edge;
        end
    end

endmodule

// File: verilog/peripheral_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peripheral subsystem
// cpu facing decoder, arbiter, ram, registers and interrupt control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module peripheral_subsystem (
    input  logic                           vdp_clk,
    input  logic                           vdp_reset,

    input  logic [soc_pkg::addr_width-1:0] cpu_address,
    input  logic                           cpu_mem_valid,
    input  logic [soc_pkg::strb_width-1:0] cpu_wstrb,
    input  logic [soc_pkg::data_width-1:0] cpu_write_data,
    output logic                           cpu_mem_ready,
    output logic [soc_pkg::data_width-1:0] cpu_read_data,

    input  logic                           frame_ended,
    input  logic                           raster_hit,
    input  logic [1:0]                     cpu_eoi,
    output logic [1:0]                     cpu_irq,

    output logic                           led_r,
    output logic                           led_b
);

    logic ram_en;
    logic status_en;
    logic dsp_en;
    logic none_en;
    logic write_en;

    logic [soc_pkg::data_width-1:0]     status_read_data;
    logic [soc_pkg::data_width-1:0]     dsp_result;
    logic [soc_pkg::data_width-1:0]     ram_read_data;
    logic                               ram_cs;
    logic [soc_pkg::strb_width-1:0]     ram_wstrb;
    logic [soc_pkg::ram_addr_width-1:0] ram_address;
    logic [soc_pkg::data_width-1:0]     ram_write_data;

    cpu_bus_if cpu_bus ();

    // cpu request onto the shared bus
    assign cpu_bus.address.raw = cpu_address;
    assign cpu_bus.write_data  = cpu_write_data;
    assign cpu_bus.wstrb       = cpu_wstrb;
    assign cpu_bus.mem_valid   = cpu_mem_valid;

    address_decoder decoder_i (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .bus       (cpu_bus.decoder),
        .ram_en    (ram_en),
        .status_en (status_en),
        .dsp_en    (dsp_en),
        .none_en   (none_en),
        .write_en  (write_en)
    );

    bus_arbiter arbiter_i (
        .vdp_clk          (vdp_clk),
        .vdp_reset        (vdp_reset),
        .bus              (cpu_bus.arbiter),
        .ram_en           (ram_en),
        .status_en        (status_en),
        .dsp_en           (dsp_en),
        .none_en          (none_en),
        .write_en         (write_en),
        .status_read_data (status_read_data),
        .dsp_result       (dsp_result),
        .ram_read_data    (ram_read_data),
        .ram_cs           (ram_cs),
        .ram_wstrb        (ram_wstrb),
        .ram_address      (ram_address),
        .ram_write_data   (ram_write_data),
        .cpu_mem_ready    (cpu_mem_ready),
        .cpu_read_data    (cpu_read_data)
    );

    cpu_ram ram_i (
        .vdp_clk    (vdp_clk),
        .cs         (ram_cs),
        .wstrb      (ram_wstrb),
        .address    (ram_address),
        .write_data (ram_write_data),
        .read_data  (ram_read_data)
    );

    system_registers regs_i (
        .vdp_clk          (vdp_clk),
        .vdp_reset        (vdp_reset),
        .bus              (cpu_bus.regs),
        .status_en        (status_en),
        .dsp_en           (dsp_en),
        .write_en         (write_en),
        .led_r            (led_r),
        .led_b            (led_b),
        .status_read_data (status_read_data),
        .dsp_result       (dsp_result)
    );

    // eoi bit 0 clears frame, bit 1 clears raster
    cpu_irq_control irq_control_i (
        .vdp_clk                (vdp_clk),
        .vdp_reset              (vdp_reset),
        .frame_irq_requested    (frame_ended),
        .raster_irq_requested   (raster_hit),
        .irq_acknowledge        (cpu_eoi[0]),
        .raster_irq_acknowledge (cpu_eoi[1]),
        .irq                    (cpu_irq)
    );

endmodule

// File: testbench/subsystem_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// subsystem model
// expected ram, register and interrupt state plus the value compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef subsystem_model_svh
`define subsystem_model_svh

logic [31:0] ram_model [2048];
logic [3:0]  ram_written [2048];
logic [1:0]  status_model;
logic [15:0] operand_a;
logic [15:0] operand_b;
logic [1:0]  irq_model;
logic [1:0]  request_prev;

task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
        $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
        $display("Done: errors found");
        $fatal(1);
    end
endtask

task automatic reset_model();
    for (int i = 0; i < 2048; i++) begin
        ram_written[i] = 4'h0;
    end
    // red LED on, blue off
    status_model = 2'b01;
    operand_a    = 16'h0000;
    operand_b    = 16'h0000;
endtask

// only lanes with a strobe take new data
task automatic merge_ram_write(input logic [10:0] index, input logic [3:0] strobe,
                               input logic [31:0] data);
    for (int lane = 0; lane < 4; lane++) begin
        if (strobe[lane]) begin
            ram_model[index][8*lane +: 8] = data[8*lane +: 8];
            ram_written[index][lane]      = 1'b1;
        end
    end
endtask

// lanes never written hold unknown data
function automatic logic [31:0] written_mask(input logic [10:0] index);
    logic [31:0] mask;
    for (int lane = 0; lane < 4; lane++) begin
        mask[8*lane +: 8] = {8{ram_written[index][lane]}};
    end
    return mask;
endfunction

function automatic logic [31:0] signed_product(input logic [15:0] a, input logic [15:0] b);
    logic signed [31:0] wide_a;
    logic signed [31:0] wide_b;
    wide_a = {{16{a[15]}}, a};
    wide_b = {{16{b[15]}}, b};
    return wide_a * wide_b;
endfunction

// a rising request beats eoi in the same cycle
task automatic step_irq_model(input logic [1:0] request, input logic [1:0] eoi);
    for (int i = 0; i < 2; i++) begin
        if (request[i] && !request_prev[i]) begin
            irq_model[i] = 1'b1;
        end else if (eoi[i]) begin
            irq_model[i] = 1'b0;
        end
    end
    request_prev = request;
endtask

`endif

// File: testbench/tb_peripheral_subsystem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peripheral subsystem testbench
// random cpu accesses and interrupt traffic checked against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_peripheral_subsystem;

    localparam int num_accesses   = 500;
    localparam int timeout_cycles = num_accesses * 4 + 100;
    // edges from driving valid until ready is seen
    localparam int ready_edges    = 3;

    logic        vdp_clk;
    logic        vdp_reset;
    logic [23:0] cpu_address;
    logic        cpu_mem_valid;
    logic [3:0]  cpu_wstrb;
    logic [31:0] cpu_write_data;
    logic        cpu_mem_ready;
    logic [31:0] cpu_read_data;
    logic        frame_ended;
    logic        raster_hit;
    logic [1:0]  cpu_eoi;
    logic [1:0]  cpu_irq;
    logic        led_r;
    logic        led_b;
    integer      seed;
    int          cycle_count = 0;

    `include "subsystem_model.svh"

    peripheral_subsystem dut_i (
        .vdp_clk        (vdp_clk),
        .vdp_reset      (vdp_reset),
        .cpu_address    (cpu_address),
        .cpu_mem_valid  (cpu_mem_valid),
        .cpu_wstrb      (cpu_wstrb),
        .cpu_write_data (cpu_write_data),
        .cpu_mem_ready  (cpu_mem_ready),
        .cpu_read_data  (cpu_read_data),
        .frame_ended    (frame_ended),
        .raster_hit     (raster_hit),
        .cpu_eoi        (cpu_eoi),
        .cpu_irq        (cpu_irq),
        .led_r          (led_r),
        .led_b          (led_b)
    );

    always #10 vdp_clk = ~vdp_clk;

    always @(posedge vdp_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("timeout: the accesses did not finish within %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    // interrupt state checked on every edge
    always @(posedge vdp_clk) begin
        if (vdp_reset) begin
            irq_model    = 2'b00;
            request_prev = 2'b00;
        end else begin
            compare_value("cpu_irq", {30'd0, irq_model}, {30'd0, cpu_irq});
            step_irq_model({raster_hit, frame_ended}, cpu_eoi);
        end
    end

    // one edge with sparse random interrupt traffic
    task automatic next_cycle();
        @(posedge vdp_clk);
        frame_ended <= ($random(seed) & 7) == 0;
        raster_hit  <= ($random(seed) & 7) == 0;
        cpu_eoi[0]  <= ($random(seed) & 3) == 0;
        cpu_eoi[1]  <= ($random(seed) & 3) == 0;
    endtask

    function automatic logic [23:0] make_address(input logic [3:0] region,
                                                 input logic [10:0] index);
        logic [6:0] filler;
        logic [1:0] offset;
        filler = 7'($random(seed));
        offset = 2'($random(seed));
        return {region, filler, index, offset};
    endfunction

    task automatic bus_access(input logic [23:0] address, input logic [3:0] strobe,
                              input logic [31:0] data, output logic [31:0] read_data);
        int edges;
        cpu_address    <= address;
        cpu_wstrb      <= strobe;
        cpu_write_data <= data;
        cpu_mem_valid  <= 1'b1;
        edges = 0;
        do begin
            next_cycle();
            edges++;
        end while (cpu_mem_ready !== 1'b1);
        compare_value("cpu_mem_ready delay", ready_edges, edges);
        read_data = cpu_read_data;
        cpu_mem_valid <= 1'b0;
        next_cycle();
        // a single ready per request
        compare_value("cpu_mem_ready", 32'd0, {31'd0, cpu_mem_ready});
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata;
        logic [10:0] index;
        logic [3:0]  strobe;
        logic [3:0]  region;
        int          kind;
        seed           = 32'hda79aafb;
        vdp_clk        = 1'b0;
        vdp_reset      = 1'b1;
        cpu_address    = 24'h0;
        cpu_mem_valid  = 1'b0;
        cpu_wstrb      = 4'h0;
        cpu_write_data = 32'h0;
        frame_ended    = 1'b0;
        raster_hit     = 1'b0;
        cpu_eoi        = 2'b00;
        reset_model();
        repeat (2) @(posedge vdp_clk);
        vdp_reset <= 1'b0;
        next_cycle();
        compare_value("cpu_mem_ready", 32'd0, {31'd0, cpu_mem_ready});
        compare_value("led_r", 32'd1, {31'd0, led_r});
        compare_value("led_b", 32'd0, {31'd0, led_b});

        for (int n = 0; n < num_accesses; n++) begin
            kind   = $random(seed) & 7;
            index  = ($random(seed) & 1) ? 11'($random(seed)) : 11'($random(seed) & 31);
            wdata  = $random(seed);
            strobe = 4'($random(seed));
            if (strobe == 4'h0) begin
                strobe = 4'hf;
            end
            case (kind)
                0, 1: begin
                    bus_access(make_address(4'd0, index), strobe, wdata, rdata);
                    merge_ram_write(index, strobe, wdata);
                end
                2, 3: begin
                    bus_access(make_address(4'd0, index), 4'h0, wdata, rdata);
                    compare_value("cpu_read_data", ram_model[index] & written_mask(index),
                                  rdata & written_mask(index));
                end
                4: begin
                    if ($random(seed) & 1) begin
                        bus_access(make_address(4'd1, index), strobe, wdata, rdata);
                        status_model = wdata[1:0];
                        compare_value("led_r", {31'd0, status_model[0]}, {31'd0, led_r});
                        compare_value("led_b", {31'd0, status_model[1]}, {31'd0, led_b});
                    end else begin
                        bus_access(make_address(4'd1, index), 4'h0, wdata, rdata);
                        compare_value("cpu_read_data", {30'd0, status_model}, rdata);
                    end
                end
                5: begin
                    // word index bit 0 picks operand b
                    bus_access(make_address(4'd2, index), strobe, wdata, rdata);
                    if (index[0]) begin
                        operand_b = wdata[15:0];
                    end else begin
                        operand_a = wdata[15:0];
                    end
                end
                6: begin
                    bus_access(make_address(4'd2, index), 4'h0, wdata, rdata);
                    compare_value("cpu_read_data", signed_product(operand_a, operand_b), rdata);
                end
                default: begin
                    region = 4'($random(seed));
                    if (region < 4'd3) begin
                        region = region + 4'd3;
                    end
                    bus_access(make_address(region, index), 4'h0, wdata, rdata);
                    compare_value("cpu_read_data", 32'd0, rdata);
                end
            endcase
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: build.f
+incdir+testbench
verilog/soc_pkg.sv
verilog/cpu_bus_if.sv
verilog/address_decoder.sv
verilog/bus_arbiter.sv
verilog/cpu_ram.sv
verilog/system_registers.sv
verilog/cpu_irq_control.sv
verilog/peripheral_subsystem.sv
testbench/tb_peripheral_subsystem.sv

// File: Makefile
# Verilator simulation of the peripheral subsystem
# sim builds and runs the testbench, then looks for the pass line in the log

sim:
	verilator --binary --timing -Wno-fatal -f build.f \
		--top-module tb_peripheral_subsystem -Mdir obj_dir -o sim_peripheral
	./obj_dir/sim_peripheral | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
